// File: project.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/bp_pkg.sv
verilog/branch_target_buffer.sv
verilog/gshare_predictor.sv
verilog/resolve_pipe.sv
verilog/branch_predictor.sv
verification/bp_ref_model.sv
verification/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

export_include_dirs:
  - verilog

sources:
  - target: rtl
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/bp_pkg.sv
      - verilog/branch_target_buffer.sv
      - verilog/gshare_predictor.sv
      - verilog/resolve_pipe.sv
      - verilog/branch_predictor.sv
  - target: verification
    files:
      - verification/bp_ref_model.sv
      - verification/tb_branch_predictor.sv

// File: verification/tb_branch_predictor.sv
// Testbench for the branch predictor with directed tests and a seeded random run against a model
`timescale 1ns/1ps

module tb_branch_predictor;
    import rv_isa_pkg::*;
    import bp_pkg::*;
    import bp_ref_model::*;

    localparam int RESET_CYCLES = 10;
    localparam int LEN_RESET    = 32;
    localparam int LEN_JUMP     = 15;
    localparam int LEN_COUNTER  = 63;
    localparam int LEN_HISTORY  = 20;
    localparam int LEN_RANDOM   = 2000;
    localparam int MAX_CYCLES   = RESET_CYCLES + LEN_RESET + LEN_JUMP + LEN_COUNTER
                                  + LEN_HISTORY + LEN_RANDOM + 100;
    // Pool slot of a plain instruction used to space out fetches
    localparam int FILL = 6;

    logic    clk;
    logic    reset_i;
    pc_t     pc_i;
    pc_t     pred_target_o;
    logic    pred_taken_o;
    logic    ex_valid_i;
    opcode_e ex_op_i;
    logic    ex_taken_i;
    pc_t     ex_target_i;
    logic    flush_i;

    // Program pool with a taken bias in percent for branches
    pc_t     prog_pc     [16];
    opcode_e prog_op     [16];
    pc_t     prog_target [16];
    int      prog_bias   [16];

    // Outcomes of the fetches in flight where entry 1 resolves next
    logic    ex_q_valid  [2];
    opcode_e ex_q_op     [2];
    logic    ex_q_taken  [2];
    pc_t     ex_q_target [2];

    int      cycle_count = 0;
    logic    got_taken;
    pc_t     got_target;

    branch_predictor DUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_i          (pc_i),
        .pred_target_o (pred_target_o),
        .pred_taken_o  (pred_taken_o),
        .ex_valid_i    (ex_valid_i),
        .ex_op_i       (ex_op_i),
        .ex_taken_i    (ex_taken_i),
        .ex_target_i   (ex_target_i),
        .flush_i       (flush_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout: the run went past its limit of %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Simulation did not reach the end of the tests");
        end
    end

    task automatic check_taken(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s, pc %h taken %b expected %b",
                     $time, what, pc_i, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Direction mismatch");
        end
    endtask

    task automatic check_target(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s, pc %h target %h expected %h",
                     $time, what, pc_i, got, exp);
            $display("TEST FAIL");
            $fatal(1, "Target mismatch");
        end
    endtask

    task automatic set_slot(input int s, input pc_t pc, input opcode_e op, input pc_t target,
                            input int bias);
        prog_pc[s]     = pc;
        prog_op[s]     = op;
        prog_target[s] = target;
        prog_bias[s]   = bias;
    endtask

    // Pairs 0/1, 2/15, 3/4 and 8/9 share a BTB index
    task automatic load_program();
        set_slot(0,  32'h0000_1000, op_jal,    32'h0000_1400, 0);
        set_slot(1,  32'h0000_1200, op_jal,    32'h0000_1800, 0);
        set_slot(2,  32'h0000_1010, op_jalr,   32'h0000_2000, 0);
        set_slot(3,  32'h0000_1020, op_branch, 32'h0000_0ff0, 90);
        set_slot(4,  32'h0000_1220, op_branch, 32'h0000_1100, 20);
        set_slot(5,  32'h0000_1030, op_branch, 32'h0000_1080, 60);
        set_slot(6,  32'h0000_1044, op_other,  32'h0000_1048, 0);
        set_slot(7,  32'h0000_1048, op_other,  32'h0000_104c, 0);
        set_slot(8,  32'h0000_2004, op_jal,    32'h0000_3000, 0);
        set_slot(9,  32'h0000_2204, op_jalr,   32'h0000_3100, 0);
        set_slot(10, 32'h0000_2040, op_branch, 32'h0000_2080, 50);
        set_slot(11, 32'h0000_2060, op_branch, 32'h0000_2000, 75);
        set_slot(12, 32'h0000_3000, op_other,  32'h0000_3004, 0);
        set_slot(13, 32'h0000_3008, op_branch, 32'h0000_3100, 10);
        set_slot(14, 32'h0000_300c, op_other,  32'h0000_3010, 0);
        set_slot(15, 32'h0000_4010, op_branch, 32'h0000_4000, 95);
    endtask

    task automatic apply_reset();
        reset_i = 1'b1;
        model_reset();
        for (int i = 0; i < 2; i++) begin
            ex_q_valid[i]  = 1'b0;
            ex_q_op[i]     = op_other;
            ex_q_taken[i]  = 1'b0;
            ex_q_target[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
    endtask

    // One fetch cycle whose outcome resolves two cycles later
    task automatic step(input pc_t pc, input opcode_e op, input pc_t target, input logic taken,
                        input logic resolve, input logic flush);
        logic exp_taken;
        pc_t  exp_target;
        @(negedge clk);
        pc_i        = pc;
        flush_i     = flush;
        ex_valid_i  = ex_q_valid[1];
        ex_op_i     = ex_q_op[1];
        ex_taken_i  = ex_q_taken[1];
        ex_target_i = ex_q_target[1];
        #10;
        model_predict(pc, exp_taken, exp_target);
        got_taken  = pred_taken_o;
        got_target = pred_target_o;
        check_taken(pred_taken_o, exp_taken, "direction differs from model");
        check_target(pred_target_o, exp_target, "target differs from model");
        @(posedge clk);
        model_update(pc, ex_valid_i, ex_op_i, ex_taken_i, ex_target_i, flush);
        ex_q_valid[1]  = ex_q_valid[0];
        ex_q_op[1]     = ex_q_op[0];
        ex_q_taken[1]  = ex_q_taken[0];
        ex_q_target[1] = ex_q_target[0];
        ex_q_valid[0]  = resolve;
        ex_q_op[0]     = op;
        ex_q_taken[0]  = taken;
        ex_q_target[0] = target;
    endtask

    task automatic fetch_slot(input int s, input logic taken, input logic resolve,
                              input logic flush);
        step(prog_pc[s], prog_op[s], prog_target[s], taken, resolve, flush);
    endtask

    task automatic reset_defaults();
        pc_t pc;
        for (int s = 0; s < 16; s++) begin
            fetch_slot(s, 1'b0, 1'b0, 1'b0);
            check_taken(got_taken, 1'b0, "taken right after reset");
            check_target(got_target, prog_pc[s] + 32'd4, "no fall-through after reset");
        end
        for (int n = 0; n < 16; n++) begin
            pc = $urandom & 32'hffff_fffc;
            step(pc, op_other, pc + 32'd4, 1'b0, 1'b0, 1'b0);
            check_taken(got_taken, 1'b0, "taken right after reset");
            check_target(got_target, pc + 32'd4, "no fall-through after reset");
        end
    endtask

    task automatic jump_allocation();
        int jumps   [3] = '{0, 2, 8};
        int aliases [3] = '{1, 15, 9};
        for (int k = 0; k < 3; k++) begin
            fetch_slot(jumps[k], 1'b1, 1'b1, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
            fetch_slot(jumps[k], 1'b0, 1'b0, 1'b0);
            check_taken(got_taken, 1'b1, "resolved jump not predicted taken");
            check_target(got_target, prog_target[jumps[k]], "resolved jump target");
            // Same index, other tag
            fetch_slot(aliases[k], 1'b0, 1'b0, 1'b0);
            check_taken(got_taken, 1'b0, "aliased pc predicted taken");
            check_target(got_target, prog_pc[aliases[k]] + 32'd4, "aliased pc hit");
        end
    endtask

    task automatic counter_training();
        fetch_slot(FILL, 1'b0, 1'b0, 1'b1);
        repeat (10) begin
            fetch_slot(5, 1'b1, 1'b1, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
        end
        fetch_slot(5, 1'b0, 1'b0, 1'b0);
        check_taken(got_taken, 1'b1, "trained branch not taken");
        check_target(got_target, prog_target[5], "trained branch target");
        repeat (10) begin
            fetch_slot(5, 1'b0, 1'b1, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
        end
        // Still a BTB hit, so the stored target comes back with a not-taken direction
        fetch_slot(5, 1'b0, 1'b0, 1'b0);
        check_taken(got_taken, 1'b0, "untrained branch still taken");
        check_target(got_target, prog_target[5], "untrained branch target");
    endtask

    task automatic history_indexing();
        // Train the zero-history counter of slot 10
        repeat (3) begin
            fetch_slot(FILL, 1'b0, 1'b0, 1'b1);
            fetch_slot(10, 1'b1, 1'b1, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
            fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
        end
        fetch_slot(FILL, 1'b0, 1'b0, 1'b1);
        fetch_slot(10, 1'b0, 1'b0, 1'b0);
        check_taken(got_taken, 1'b1, "zero-history counter not taken");
        check_target(got_target, prog_target[10], "branch target with zero history");
        // Another taken branch puts a one into the history
        fetch_slot(13, 1'b1, 1'b1, 1'b0);
        fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
        fetch_slot(FILL, 1'b0, 1'b0, 1'b0);
        fetch_slot(10, 1'b0, 1'b0, 1'b0);
        check_taken(got_taken, 1'b0, "other history reused the trained counter");
        check_target(got_target, prog_target[10], "branch target with other history");
        fetch_slot(FILL, 1'b0, 1'b0, 1'b1);
        fetch_slot(10, 1'b0, 1'b0, 1'b0);
        check_taken(got_taken, 1'b1, "flush did not return to zero history");
    endtask

    task automatic random_run();
        int   s;
        logic taken;
        logic resolve;
        logic flush;
        repeat (LEN_RANDOM) begin
            s = $urandom % 16;
            case (prog_op[s])
                op_branch: taken = ($urandom % 100) < prog_bias[s];
                op_jal,
                op_jalr:   taken = ($urandom % 10) != 0;
                default:   taken = 1'b0;
            endcase
            resolve = ($urandom % 10) != 0;
            flush   = ($urandom % 32) == 0;
            fetch_slot(s, taken, resolve, flush);
        end
    endtask

    initial begin
        void'($urandom(32'hdb23));
        reset_i     = 1'b1;
        pc_i        = '0;
        ex_valid_i  = 1'b0;
        ex_op_i     = op_other;
        ex_taken_i  = 1'b0;
        ex_target_i = '0;
        flush_i     = 1'b0;
        load_program();
        apply_reset();
        reset_defaults();
        jump_allocation();
        counter_training();
        history_indexing();
        random_run();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verification/bp_ref_model.sv
// Reference model of the fetch-stage branch predictor used by the testbench
`include "bp_defines.svh"

package bp_ref_model;
    import rv_isa_pkg::*;
    import bp_pkg::*;

    logic         m_btb_valid  [BTB_ENTRIES];
    btb_tag_t     m_btb_tag    [BTB_ENTRIES];
    pc_t          m_btb_target [BTB_ENTRIES];
    btb_kind_e    m_btb_kind   [BTB_ENTRIES];
    pht_counter_t m_pht        [PHT_ENTRIES];
    ghr_t         m_ghr;

    // Fetches in flight, entry 1 reaches execute at the next edge
    pc_t          m_pend_pc    [2];
    pht_index_t   m_pend_index [2];

    function automatic void model_reset();
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_pht[i] = `BP_PHT_INIT;
        end
        m_ghr = '0;
        for (int i = 0; i < 2; i++) begin
            m_pend_pc[i]    = '0;
            m_pend_index[i] = '0;
        end
    endfunction

    // Gshare index, PC word bits XORed with the current history
    function automatic pht_index_t pht_index_of(input pc_t pc);
        return pc[`BP_GHR_BITS+1:2] ^ m_ghr;
    endfunction

    function automatic void model_predict(input pc_t pc, output logic taken, output pc_t target);
        btb_index_t idx;
        idx    = pc[BTB_INDEX_BITS+1:2];
        taken  = 1'b0;
        target = pc + 32'd4;
        if (m_btb_valid[idx] && (m_btb_tag[idx] == pc[31:BTB_INDEX_BITS+2])) begin
            target = m_btb_target[idx];
            if (m_btb_kind[idx] == kind_jump) begin
                taken = 1'b1;
            end else begin
                taken = m_pht[pht_index_of(pc)][1];
            end
        end
    endfunction

    // One rising edge: resolve the oldest fetch, then take in the current one
    function automatic void model_update(input pc_t pc, input logic ex_valid, input opcode_e ex_op,
                                         input logic ex_taken, input pc_t ex_target,
                                         input logic flush);
        pht_index_t fetch_index;
        pc_t        ex_pc;
        pht_index_t ex_index;
        btb_index_t slot;
        fetch_index = pht_index_of(pc);
        ex_pc       = m_pend_pc[1];
        ex_index    = m_pend_index[1];
        if (ex_valid && ex_taken && (ex_op == op_jal || ex_op == op_jalr || ex_op == op_branch)) begin
            slot               = ex_pc[BTB_INDEX_BITS+1:2];
            m_btb_valid[slot]  = 1'b1;
            m_btb_tag[slot]    = ex_pc[31:BTB_INDEX_BITS+2];
            m_btb_target[slot] = ex_target;
            m_btb_kind[slot]   = (ex_op == op_branch) ? kind_branch : kind_jump;
        end
        if (ex_valid && (ex_op == op_branch)) begin
            if (ex_taken && (m_pht[ex_index] != 2'b11)) begin
                m_pht[ex_index] = m_pht[ex_index] + 2'd1;
            end else if (!ex_taken && (m_pht[ex_index] != 2'b00)) begin
                m_pht[ex_index] = m_pht[ex_index] - 2'd1;
            end
            m_ghr = {ex_taken, m_ghr[`BP_GHR_BITS-1:1]};
        end
        if (flush) begin
            m_ghr = '0;
        end
        m_pend_pc[1]    = m_pend_pc[0];
        m_pend_index[1] = m_pend_index[0];
        m_pend_pc[0]    = pc;
        m_pend_index[0] = fetch_index;
    endfunction

endpackage

// File: verilog/branch_predictor.sv
// Fetch-stage branch predictor combining BTB, gshare and the resolve pipe
`timescale 1ns/1ps

module branch_predictor (
    input  logic                clk,
    input  logic                reset_i,
    input  rv_isa_pkg::pc_t     pc_i,
    output rv_isa_pkg::pc_t     pred_target_o,
    output logic                pred_taken_o,
    input  logic                ex_valid_i,
    input  rv_isa_pkg::opcode_e ex_op_i,
    input  logic                ex_taken_i,
    input  rv_isa_pkg::pc_t     ex_target_i,
    input  logic                flush_i
);
    import rv_isa_pkg::*;
    import bp_pkg::*;

    logic       btb_hit;
    btb_kind_e  btb_kind;
    pc_t        btb_target;
    logic       gs_taken;
    pht_index_t gs_index;

    pc_t        ex_pc;
    pht_index_t ex_pht_index;

    logic       ex_is_ctrl;
    logic       btb_upd_en;
    logic       pht_upd_en;

    // Execute-side decode
    assign ex_is_ctrl = (ex_op_i == op_jal) || (ex_op_i == op_jalr) || (ex_op_i == op_branch);
    assign btb_upd_en = ex_valid_i && ex_is_ctrl && ex_taken_i;
    assign pht_upd_en = ex_valid_i && (ex_op_i == op_branch);

    branch_target_buffer u_btb (
        .clk          (clk),
        .reset_i      (reset_i),
        .lookup_pc_i  (pc_i),
        .upd_en_i     (btb_upd_en),
        .upd_pc_i     (ex_pc),
        .upd_target_i (ex_target_i),
        .upd_op_i     (ex_op_i),
        .hit_o        (btb_hit),
        .kind_o       (btb_kind),
        .target_o     (btb_target)
    );

    gshare_predictor u_gshare (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .upd_en_i    (pht_upd_en),
        .upd_index_i (ex_pht_index),
        .upd_taken_i (ex_taken_i),
        .flush_i     (flush_i),
        .taken_o     (gs_taken),
        .index_o     (gs_index)
    );

    // ex_hit is left for the core's misprediction logic
    resolve_pipe u_resolve (
        .clk        (clk),
        .reset_i    (reset_i),
        .f_pc_i     (pc_i),
        .f_index_i  (gs_index),
        .f_hit_i    (btb_hit),
        .ex_pc_o    (ex_pc),
        .ex_index_o (ex_pht_index),
        .ex_hit_o   ()
    );

    // Jumps that hit are always taken, branches follow the counter
    always_comb begin
        if (btb_hit && (btb_kind == kind_jump)) begin
            pred_taken_o  = 1'b1;
            pred_target_o = btb_target;
        end else if (btb_hit && (btb_kind == kind_branch)) begin
            pred_taken_o  = gs_taken;
            pred_target_o = btb_target;
        end else begin
            pred_taken_o  = 1'b0;
            pred_target_o = pc_i + 32'd4;
        end
    end

endmodule

// File: verilog/resolve_pipe.sv
// Two-stage carrier of per-fetch predictor state from fetch to execute
`timescale 1ns/1ps

module resolve_pipe (
    input  logic               clk,
    input  logic               reset_i,
    input  rv_isa_pkg::pc_t    f_pc_i,
    input  bp_pkg::pht_index_t f_index_i,
    input  logic               f_hit_i,
    output rv_isa_pkg::pc_t    ex_pc_o,
    output bp_pkg::pht_index_t ex_index_o,
    output logic               ex_hit_o
);
    import rv_isa_pkg::*;
    import bp_pkg::*;

    // Decode stage copy
    pc_t        d_pc_q;
    pht_index_t d_index_q;
    logic       d_hit_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            d_hit_q  <= 1'b0;
            ex_hit_o <= 1'b0;
        end else begin
            d_hit_q  <= f_hit_i;
            ex_hit_o <= d_hit_q;
        end
    end

    // PC and index stages
    always_ff @(posedge clk) begin
        d_pc_q     <= f_pc_i;
        d_index_q  <= f_index_i;
        ex_pc_o    <= d_pc_q;
        ex_index_o <= d_index_q;
    end

    // Both stages must have flushed out before a hit may appear
    no_hit_after_reset: assert property (
        @(posedge clk)
        reset_i ##1 !reset_i |-> !ex_hit_o ##1 !ex_hit_o
    ) else $error("Execute hit seen within two cycles of reset");

endmodule

// File: verilog/gshare_predictor.sv
// Gshare direction predictor with saturating counters and global history
`timescale 1ns/1ps
`include "bp_defines.svh"

module gshare_predictor (
    input  logic                   clk,
    input  logic                   reset_i,
    input  rv_isa_pkg::pc_t        pc_i,
    input  logic                   upd_en_i,
    input  bp_pkg::pht_index_t     upd_index_i,
    input  logic                   upd_taken_i,
    input  logic                   flush_i,
    output logic                   taken_o,
    output bp_pkg::pht_index_t     index_o
);
    import rv_isa_pkg::*;
    import bp_pkg::*;

    pht_counter_t pht_q [PHT_ENTRIES];
    ghr_t         ghr_q;
    pht_counter_t upd_count;

    // Hash the low PC word bits with the history
    assign index_o = pc_i[`BP_GHR_BITS+1:2] ^ ghr_q;
    assign taken_o = pht_q[index_o][1];

    assign upd_count = pht_q[upd_index_i];

    // Counter update, saturating at both ends
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= `BP_PHT_INIT;
            end
        end else if (upd_en_i) begin
            if (upd_taken_i && (upd_count != 2'b11)) begin
                pht_q[upd_index_i] <= upd_count + 2'd1;
            end else if (!upd_taken_i && (upd_count != 2'b00)) begin
                pht_q[upd_index_i] <= upd_count - 2'd1;
            end
        end
    end

    // History takes the resolved outcome, not the prediction
    // Flush wins over a same-cycle update
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            ghr_q <= '0;
        end else if (upd_en_i) begin
            ghr_q <= {upd_taken_i, ghr_q[`BP_GHR_BITS-1:1]};
        end
    end

    pht_no_wrap_up: assert property (
        @(posedge clk) disable iff (reset_i)
        upd_en_i && upd_taken_i && (upd_count == 2'b11)
            |=> pht_q[$past(upd_index_i)] == 2'b11
    ) else $error("PHT counter wrapped past strongly taken");

    pht_no_wrap_down: assert property (
        @(posedge clk) disable iff (reset_i)
        upd_en_i && !upd_taken_i && (upd_count == 2'b00)
            |=> pht_q[$past(upd_index_i)] == 2'b00
    ) else $error("PHT counter wrapped past strongly not taken");

    ghr_cleared_by_flush: assert property (
        @(posedge clk) disable iff (reset_i)
        flush_i |=> (ghr_q == '0)
    ) else $error("GHR not cleared one cycle after flush");

endmodule

// File: verilog/branch_target_buffer.sv
// Branch target buffer with combinational lookup and allocate-on-taken update
`timescale 1ns/1ps

module branch_target_buffer (
    input  logic                clk,
    input  logic                reset_i,
    input  rv_isa_pkg::pc_t     lookup_pc_i,
    input  logic                upd_en_i,
    input  rv_isa_pkg::pc_t     upd_pc_i,
    input  rv_isa_pkg::pc_t     upd_target_i,
    input  rv_isa_pkg::opcode_e upd_op_i,
    output logic                hit_o,
    output bp_pkg::btb_kind_e   kind_o,
    output rv_isa_pkg::pc_t     target_o
);
    import rv_isa_pkg::*;
    import bp_pkg::*;

    // Entry storage, only the valid bits are cleared by reset
    logic       valid_q  [BTB_ENTRIES];
    btb_tag_t   tag_q    [BTB_ENTRIES];
    pc_t        target_q [BTB_ENTRIES];
    btb_kind_e  kind_q   [BTB_ENTRIES];

    btb_index_t lookup_index;
    btb_tag_t   lookup_tag;
    btb_index_t upd_index;
    btb_tag_t   upd_tag;
    btb_kind_e  upd_kind;

    // Split each PC into index and tag
    // Bits 1:0 are always zero for RV32I without compressed instructions
    assign lookup_index = lookup_pc_i[BTB_INDEX_BITS+1:2];
    assign lookup_tag   = lookup_pc_i[31:BTB_INDEX_BITS+2];
    assign upd_index    = upd_pc_i[BTB_INDEX_BITS+1:2];
    assign upd_tag      = upd_pc_i[31:BTB_INDEX_BITS+2];

    // Lookup path
    assign hit_o    = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign kind_o   = hit_o ? kind_q[lookup_index] : kind_none;
    assign target_o = target_q[lookup_index];

    // Jumps of either form share one kind, they are always predicted taken
    always_comb begin
        case (upd_op_i)
            op_jal,
            op_jalr: begin
                upd_kind = kind_jump;
            end
            op_branch: begin
                upd_kind = kind_branch;
            end
            default: begin
                upd_kind = kind_none;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_en_i) begin
            valid_q[upd_index] <= 1'b1;
        end
    end

    // A new entry simply replaces whatever held the slot before
    always_ff @(posedge clk) begin
        if (upd_en_i) begin
            tag_q[upd_index]    <= upd_tag;
            target_q[upd_index] <= upd_target_i;
            kind_q[upd_index]   <= upd_kind;
        end
    end

    // Entries are only ever allocated by control transfers
    hit_has_kind: assert property (
        @(posedge clk) disable iff (reset_i)
        hit_o |-> (kind_o != kind_none)
    ) else $error("BTB hit returned an entry without a kind");

endmodule

// File: verilog/bp_pkg.sv
// Predictor table and history types for the BTB and gshare blocks
`include "bp_defines.svh"

package bp_pkg;

    localparam int unsigned BTB_ENTRIES    = `BP_BTB_ENTRIES;
    localparam int unsigned BTB_INDEX_BITS = $clog2(`BP_BTB_ENTRIES);
    localparam int unsigned PHT_ENTRIES    = 2 ** `BP_GHR_BITS;

    // PC word bits just above bit 1
    typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;

    // Remaining PC bits above the index
    typedef logic [29-BTB_INDEX_BITS:0] btb_tag_t;

    // Newest outcome in the MSB, older ones move toward the LSB
    typedef logic [`BP_GHR_BITS-1:0] ghr_t;

    typedef logic [`BP_GHR_BITS-1:0] pht_index_t;

    // 2-bit saturating counter, MSB is the predicted direction
    typedef logic [1:0] pht_counter_t;

    typedef enum logic [1:0] {
        kind_none   = 2'd0,
        kind_jump   = 2'd1,
        kind_branch = 2'd2
    } btb_kind_e;

endpackage

// File: verilog/rv_isa_pkg.sv
// RISC-V instruction stream types used by the fetch-stage predictor
package rv_isa_pkg;

    // Byte address of an instruction
    typedef logic [31:0] pc_t;

    // Major opcodes the predictor cares about
    // op_other stands in for every opcode that does not transfer control
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_other  = 7'b0010011
    } opcode_e;

endpackage

// File: verilog/bp_defines.svh
// Branch predictor sizing macros shared by the packages and the RTL
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Number of direct-mapped BTB entries, must be a power of two
`define BP_BTB_ENTRIES 128

// Global history length
// Also sets the PHT index width, so the PHT holds 2**BP_GHR_BITS counters
`define BP_GHR_BITS 5

// Counter value after reset (strongly not taken)
`define BP_PHT_INIT 2'b00

`endif
